/* flist.f */
rtl/tetrisPkg.sv
rtl/keyInput.sv
rtl/pieceShapes.sv
rtl/boardStore.sv
rtl/gameSequencer.sv
rtl/tetrisTop.sv
tests/tetrisProperties.sv
tests/tetrisTb.sv

/* tests/tetrisTb.sv */
`timescale 1ns/1ps

module tetrisTb;
    import tetrisPkg::*;

    localparam int NumRows = HiddenRows + BoardHeight;

    logic                               clk;
    logic                               rst;
    logic                               left;
    logic                               right;
    logic                               up;
    logic                               down;
    scoreT                              score;
    pieceTypeT                          nextBlock;
    logic [BoardWidth*BoardHeight-1:0]  objects;
    logic                               fail;
    logic                               ready;

    // Stimulus table, one entry per group of identical presses
    string  testName  [$];
    keyCmdT testKey   [$];
    int     testCount [$];
    int     testScore [$];
    logic   testFail  [$];

    // Reference board model
    logic [BoardWidth-1:0]             refGrid [NumRows];
    int                                refType;
    int                                refRot;
    int                                refX;
    int                                refY;
    int                                refScore;
    int                                refNext;
    logic                              refFail;
    int                                cellXs [4];
    int                                cellYs [4];
    logic [BoardWidth*BoardHeight-1:0] expImage;

    // Offsets of the three cells around the centre, per piece type
    int baseDx [5][3] = '{'{-2, -1, 1}, '{0, 1, 1}, '{-1, 0, 1}, '{-1, 1, 1}, '{-1, 0, 1}};
    int baseDy [5][3] = '{'{0, 0, 0}, '{-1, -1, 0}, '{0, -1, 0}, '{0, 0, -1}, '{0, -1, -1}};

    int checkCount;
    int errorCount;
    int cycleCount;
    int cycleLimit;

    tetrisTop i_dut (
        .clk       (clk),
        .rst       (rst),
        .left      (left),
        .right     (right),
        .up        (up),
        .down      (down),
        .score     (score),
        .nextBlock (nextBlock),
        .objects   (objects),
        .fail      (fail),
        .ready     (ready)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: the DUT did not finish the tests within %0d cycles", cycleLimit);
            $display("Checks: %0d, errors: %0d", checkCount, errorCount);
            $display("Test failures found");
            $finish;
        end
    end

    // ####################################################################
    // Reference model
    // ####################################################################

    task automatic computeCells(input int t, input int r, input int x, input int y);
        int dx;
        int dy;
        int tmp;
        int turns;
        turns = (t == 1) ? 0 : r;
        cellXs[0] = x;
        cellYs[0] = y;
        for (int i = 0; i < 3; i++) begin
            dx = baseDx[t][i];
            dy = baseDy[t][i];
            // Clockwise quarter turn
            for (int k = 0; k < turns; k++) begin
                tmp = dx;
                dx  = -dy;
                dy  = tmp;
            end
            cellXs[i + 1] = x + dx;
            cellYs[i + 1] = y + dy;
        end
    endtask

    function automatic logic collides();
        logic blocked;
        blocked = 1'b0;
        for (int i = 0; i < 4; i++) begin
            if (cellXs[i] < 0 || cellXs[i] >= BoardWidth || cellYs[i] < 0
                    || cellYs[i] >= NumRows) begin
                blocked = 1'b1;
            end else if (refGrid[cellYs[i]][cellXs[i]]) begin
                blocked = 1'b1;
            end
        end
        return blocked;
    endfunction

    task automatic resetModel();
        for (int r = 0; r < NumRows; r++) begin
            refGrid[r] = '0;
        end
        refType  = 0;
        refRot   = 0;
        refX     = SpawnX;
        refY     = SpawnY;
        refScore = 0;
        refNext  = 1;
        refFail  = 1'b0;
    endtask

    task automatic landPiece();
        int   writeRow;
        int   removed;
        logic hidden;
        computeCells(refType, refRot, refX, refY);
        for (int i = 0; i < 4; i++) begin
            refGrid[cellYs[i]][cellXs[i]] = 1'b1;
        end
        refScore = refScore + LandPoints;

        // Keep the rows that are not full, packed against the floor
        writeRow = NumRows - 1;
        removed  = 0;
        for (int r = NumRows - 1; r >= 0; r--) begin
            if (&refGrid[r]) begin
                removed++;
            end else begin
                refGrid[writeRow] = refGrid[r];
                writeRow--;
            end
        end
        for (int r = writeRow; r >= 0; r--) begin
            refGrid[r] = '0;
        end
        refScore = refScore + LinePoints * removed;

        hidden = 1'b0;
        for (int r = 0; r < HiddenRows; r++) begin
            hidden = hidden | (|refGrid[r]);
        end
        if (hidden) begin
            refFail = 1'b1;
        end else begin
            computeCells(refNext, 0, SpawnX, SpawnY);
            if (collides()) begin
                refFail = 1'b1;
            end else begin
                refType = refNext;
                refRot  = 0;
                refX    = SpawnX;
                refY    = SpawnY;
            end
            refNext = (refNext + 1) % NumPieceTypes;
        end
    endtask

    task automatic applyModel(input keyCmdT key);
        int nx;
        int ny;
        int nr;
        if (!refFail) begin
            nx = refX;
            ny = refY;
            nr = refRot;
            case (key)
                cmdLeft:  nx = refX - 1;
                cmdRight: nx = refX + 1;
                cmdDrop:  ny = refY + 1;
                default:  nr = (refRot + 1) % 4;
            endcase
            computeCells(refType, nr, nx, ny);
            if (!collides()) begin
                refX   = nx;
                refY   = ny;
                refRot = nr;
            end else if (key == cmdDrop) begin
                landPiece();
            end
        end
    endtask

    task automatic buildImage();
        expImage = '0;
        for (int r = 0; r < BoardHeight; r++) begin
            for (int c = 0; c < BoardWidth; c++) begin
                expImage[BoardWidth * r + c] = refGrid[r + HiddenRows][c];
            end
        end
        computeCells(refType, refRot, refX, refY);
        for (int i = 0; i < 4; i++) begin
            if (cellYs[i] >= HiddenRows) begin
                expImage[BoardWidth * (cellYs[i] - HiddenRows) + cellXs[i]] = 1'b1;
            end
        end
    endtask

    // ####################################################################
    // Stimulus and checks
    // ####################################################################

    task automatic addTest(string name, keyCmdT key, int count, int expScore, logic expFail);
        testName.push_back(name);
        testKey.push_back(key);
        testCount.push_back(count);
        testScore.push_back(expScore);
        testFail.push_back(expFail);
    endtask

    task automatic fillTable();
        addTest("bar into view",    cmdDrop,     4,  0, 1'b0);
        addTest("bar left wall",    cmdLeft,     5,  0, 1'b0);
        addTest("bar right wall",   cmdRight,    8,  0, 1'b0);
        addTest("bar back left",    cmdLeft,     6,  0, 1'b0);
        addTest("bar to floor",     cmdDrop,    18,  1, 1'b0);
        addTest("square rotate",    cmdRotate,   2,  1, 1'b0);
        addTest("square left",      cmdLeft,     1,  1, 1'b0);
        addTest("square to floor",  cmdDrop,    22,  2, 1'b0);
        addTest("tee right",        cmdRight,    2,  2, 1'b0);
        addTest("tee full turn",    cmdRotate,   4,  2, 1'b0);
        addTest("tee to floor",     cmdDrop,    22,  3, 1'b0);
        addTest("ell turn",         cmdRotate,   3,  3, 1'b0);
        addTest("ell right wall",   cmdRight,    5,  3, 1'b0);
        addTest("ell turn at wall", cmdRotate,   1,  3, 1'b0);
        addTest("ell clears row",   cmdDrop,    21, 14, 1'b0);
        // Stack everything at the spawn column
        addTest("skew at centre",   cmdDrop,    21, 15, 1'b0);
        addTest("bar above stack",  cmdDrop,    18, 15, 1'b0);
        addTest("bar turn blocked", cmdRotate,   1, 15, 1'b0);
        addTest("bar lands",        cmdDrop,     1, 16, 1'b0);
        addTest("stack to top",     cmdDrop,   110, 27, 1'b1);
        addTest("moves after over", cmdLeft,     3, 27, 1'b1);
        addTest("turn after over",  cmdRotate,   2, 27, 1'b1);
        addTest("drop after over",  cmdDrop,     3, 27, 1'b1);
    endtask

    task automatic setKey(input keyCmdT key, input logic level);
        case (key)
            cmdLeft:  left  = level;
            cmdRight: right = level;
            cmdDrop:  down  = level;
            default:  up    = level;
        endcase
    endtask

    // All waits sample one ns after the rising edge
    task automatic pressKey(input keyCmdT key);
        while (!ready && !fail) begin
            @(posedge clk);
            #1;
        end
        setKey(key, 1'b1);
        @(posedge clk);
        #1;
        setKey(key, 1'b0);
        @(posedge clk);
        #1;
        // Command taken, then finished
        while (ready && !fail) begin
            @(posedge clk);
            #1;
        end
        while (!ready && !fail) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic comparePress(input string name);
        buildImage();
        checkCount++;
        assert (objects === expImage) else begin
            errorCount++;
            $display("error: %s objects expected %h actual %h", name, expImage, objects);
        end
        checkCount++;
        assert (score === scoreT'(refScore)) else begin
            errorCount++;
            $display("error: %s score expected %0d actual %0d", name, refScore, score);
        end
        checkCount++;
        assert (nextBlock === pieceTypeT'(refNext)) else begin
            errorCount++;
            $display("error: %s nextBlock expected %0d actual %0d", name, refNext, nextBlock);
        end
        checkCount++;
        assert (fail === refFail) else begin
            errorCount++;
            $display("error: %s fail expected %0b actual %0b", name, refFail, fail);
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        left       = 1'b0;
        right      = 1'b0;
        up         = 1'b0;
        down       = 1'b0;
        checkCount = 0;
        errorCount = 0;
        cycleCount = 0;
        fillTable();
        cycleLimit = 0;
        foreach (testCount[i]) begin
            cycleLimit = cycleLimit + testCount[i] * 60;
        end
        resetModel();

        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        // Spawned bar sits in a hidden row, so the image is empty
        comparePress("reset state");
        checkCount++;
        assert (ready === 1'b1) else begin
            errorCount++;
            $display("error: reset state ready expected 1 actual %0b", ready);
        end

        for (int t = 0; t < testName.size(); t++) begin
            for (int n = 0; n < testCount[t]; n++) begin
                pressKey(testKey[t]);
                applyModel(testKey[t]);
                comparePress(testName[t]);
            end
            checkCount++;
            assert (score === scoreT'(testScore[t])) else begin
                errorCount++;
                $display("error: %s final score expected %0d actual %0d",
                         testName[t], testScore[t], score);
            end
            checkCount++;
            assert (fail === testFail[t]) else begin
                errorCount++;
                $display("error: %s final fail expected %0b actual %0b",
                         testName[t], testFail[t], fail);
            end
        end

        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* tests/tetrisProperties.sv */
`timescale 1ns/1ps

module tetrisProperties (
    input logic                clk,
    input logic                rst,
    input tetrisPkg::keyCmdT   cmd,
    input logic                ready,
    input tetrisPkg::scoreT    score,
    input logic                lockPiece,
    input logic                fail
);
    import tetrisPkg::*;

    // Game over is left only through reset
    failSticky: assert property (@(posedge clk) disable iff (rst) fail |=> fail)
        else $error("fail fell while reset was low");

    // An accepted command moves the sequencer out of idle
    readyBusy: assert property (@(posedge clk) disable iff (rst)
        (ready && (cmd != cmdNone)) |=> !ready)
        else $error("ready stayed high after a command was accepted");

    scoreRises: assert property (@(posedge clk) disable iff (rst) score >= $past(score))
        else $error("score decreased");

    // One lock per landed piece
    lockSingle: assert property (@(posedge clk) disable iff (rst) lockPiece |=> !lockPiece)
        else $error("lockPiece high in two consecutive cycles");

endmodule

bind gameSequencer tetrisProperties i_props (
    .clk       (clk),
    .rst       (rst),
    .cmd       (cmd),
    .ready     (ready),
    .score     (score),
    .lockPiece (lockPiece),
    .fail      (fail)
);

/* rtl/tetrisTop.sv */
`timescale 1ns/1ps

module tetrisTop #(
    parameter int BoardWidth  = tetrisPkg::BoardWidth,
    parameter int BoardHeight = tetrisPkg::BoardHeight
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              left,
    input  logic                              right,
    input  logic                              up,
    input  logic                              down,
    output tetrisPkg::scoreT                  score,
    output tetrisPkg::pieceTypeT              nextBlock,
    output logic [BoardWidth*BoardHeight-1:0] objects,
    output logic                              fail,
    output logic                              ready
);
    import tetrisPkg::*;

    keyCmdT    cmd;
    pieceTypeT candType;
    rotationT  candRot;
    cellXT     candX;
    cellYT     candY;
    pieceTypeT curType;
    rotationT  curRot;
    cellXT     curX;
    cellYT     curY;
    cellXT     candCellX [4];
    cellYT     candCellY [4];
    cellXT     curCellX  [4];
    cellYT     curCellY  [4];
    logic       hit;
    logic       lockPiece;
    logic       clearStart;
    logic       clearDone;
    logic [2:0] rowsRemoved;
    logic       overflow;

    keyInput i_keyInput (
        .clk   (clk),
        .rst   (rst),
        .left  (left),
        .right (right),
        .up    (up),
        .down  (down),
        .cmd   (cmd)
    );

    gameSequencer #(
        .BoardWidth  (BoardWidth),
        .BoardHeight (BoardHeight)
    ) i_sequencer (
        .clk         (clk),
        .rst         (rst),
        .cmd         (cmd),
        .hit         (hit),
        .clearDone   (clearDone),
        .rowsRemoved (rowsRemoved),
        .overflow    (overflow),
        .candType    (candType),
        .candRot     (candRot),
        .candX       (candX),
        .candY       (candY),
        .curType     (curType),
        .curRot      (curRot),
        .curX        (curX),
        .curY        (curY),
        .lockPiece   (lockPiece),
        .clearStart  (clearStart),
        .ready       (ready),
        .score       (score),
        .nextBlock   (nextBlock),
        .fail        (fail)
    );

    // Cells of the piece under test
    pieceShapes i_candShape (
        .pieceType (candType),
        .rotation  (candRot),
        .centerX   (candX),
        .centerY   (candY),
        .cellX     (candCellX),
        .cellY     (candCellY)
    );

    // Cells of the piece in play
    pieceShapes i_curShape (
        .pieceType (curType),
        .rotation  (curRot),
        .centerX   (curX),
        .centerY   (curY),
        .cellX     (curCellX),
        .cellY     (curCellY)
    );

    boardStore #(
        .BoardWidth  (BoardWidth),
        .BoardHeight (BoardHeight)
    ) i_board (
        .clk         (clk),
        .rst         (rst),
        .candX       (candCellX),
        .candY       (candCellY),
        .curX        (curCellX),
        .curY        (curCellY),
        .lockPiece   (lockPiece),
        .clearStart  (clearStart),
        .hit         (hit),
        .clearDone   (clearDone),
        .rowsRemoved (rowsRemoved),
        .overflow    (overflow),
        .objects     (objects)
    );

endmodule

/* rtl/gameSequencer.sv */
`timescale 1ns/1ps

module gameSequencer #(
    parameter int BoardWidth  = tetrisPkg::BoardWidth,
    parameter int BoardHeight = tetrisPkg::BoardHeight
) (
    input  logic                 clk,
    input  logic                 rst,
    input  tetrisPkg::keyCmdT    cmd,
    input  logic                 hit,
    input  logic                 clearDone,
    input  logic [2:0]           rowsRemoved,
    input  logic                 overflow,
    output tetrisPkg::pieceTypeT candType,
    output tetrisPkg::rotationT  candRot,
    output tetrisPkg::cellXT     candX,
    output tetrisPkg::cellYT     candY,
    output tetrisPkg::pieceTypeT curType,
    output tetrisPkg::rotationT  curRot,
    output tetrisPkg::cellXT     curX,
    output tetrisPkg::cellYT     curY,
    output logic                 lockPiece,
    output logic                 clearStart,
    output logic                 ready,
    output tetrisPkg::scoreT     score,
    output tetrisPkg::pieceTypeT nextBlock,
    output logic                 fail
);
    import tetrisPkg::*;

    localparam int NumRows = HiddenRows + BoardHeight;

    // Keep the spawn centre inside a narrow or short board
    localparam int SpawnCol = (SpawnX > BoardWidth - 2) ? BoardWidth - 2 : SpawnX;
    localparam int SpawnRow = (SpawnY > NumRows - 1) ? NumRows - 1 : SpawnY;

    seqStateT state;
    keyCmdT   lastCmd;
    scoreT    lineBonus;

    assign lineBonus = scoreT'(LinePoints) * scoreT'(rowsRemoved);

    // Commands are only taken while waiting in idle
    assign ready = (state == stIdle);

    function automatic pieceTypeT nextType(pieceTypeT t);
        return (t == pieceTypeT'(NumPieceTypes - 1)) ? '0 : t + 3'd1;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= stIdle;
            lastCmd    <= cmdNone;
            candType   <= '0;
            candRot    <= '0;
            candX      <= cellXT'(SpawnCol);
            candY      <= cellYT'(SpawnRow);
            curType    <= '0;
            curRot     <= '0;
            curX       <= cellXT'(SpawnCol);
            curY       <= cellYT'(SpawnRow);
            lockPiece  <= 1'b0;
            clearStart <= 1'b0;
            score      <= '0;
            nextBlock  <= 3'd1;
            fail       <= 1'b0;
        end else begin
            lockPiece  <= 1'b0;
            clearStart <= 1'b0;

            case (state)
                stIdle: begin
                    if (cmd != cmdNone) begin
                        candType <= curType;
                        candRot  <= curRot;
                        candX    <= curX;
                        candY    <= curY;
                        case (cmd)
                            cmdLeft:  candX <= curX - cellXT'(1);
                            cmdRight: candX <= curX + cellXT'(1);
                            cmdDrop:  candY <= curY + cellYT'(1);
                            // Rotate
                            default:  candRot <= curRot + 2'd1;
                        endcase
                        lastCmd <= cmd;
                        state   <= stCheck;
                    end
                end

                stCheck: begin
                    if (!hit) begin
                        curRot <= candRot;
                        curX   <= candX;
                        curY   <= candY;
                        state  <= stIdle;
                    end else if (lastCmd == cmdDrop) begin
                        // Piece rests on something, settle it where it is
                        lockPiece <= 1'b1;
                        state     <= stLock;
                    end else begin
                        state <= stIdle;
                    end
                end

                stLock: begin
                    score      <= score + scoreT'(LandPoints);
                    clearStart <= 1'b1;
                    state      <= stClear;
                end

                stClear: begin
                    if (clearDone) begin
                        score <= score + lineBonus;
                        if (overflow) begin
                            fail  <= 1'b1;
                            state <= stOver;
                        end else begin
                            candType  <= nextBlock;
                            candRot   <= '0;
                            candX     <= cellXT'(SpawnCol);
                            candY     <= cellYT'(SpawnRow);
                            nextBlock <= nextType(nextBlock);
                            state     <= stSpawn;
                        end
                    end
                end

                stSpawn: begin
                    if (hit) begin
                        fail  <= 1'b1;
                        state <= stOver;
                    end else begin
                        curType <= candType;
                        curRot  <= candRot;
                        curX    <= candX;
                        curY    <= candY;
                        state   <= stIdle;
                    end
                end

                // Game over holds until reset
                stOver: state <= stOver;

                default: state <= stIdle;
            endcase
        end
    end

endmodule

/* rtl/boardStore.sv */
`timescale 1ns/1ps

module boardStore #(
    parameter int BoardWidth  = tetrisPkg::BoardWidth,
    parameter int BoardHeight = tetrisPkg::BoardHeight
) (
    input  logic                              clk,
    input  logic                              rst,
    input  tetrisPkg::cellXT                  candX [4],
    input  tetrisPkg::cellYT                  candY [4],
    input  tetrisPkg::cellXT                  curX  [4],
    input  tetrisPkg::cellYT                  curY  [4],
    input  logic                              lockPiece,
    input  logic                              clearStart,
    output logic                              hit,
    output logic                              clearDone,
    output logic [2:0]                        rowsRemoved,
    output logic                              overflow,
    output logic [BoardWidth*BoardHeight-1:0] objects
);
    import tetrisPkg::*;

    localparam int NumRows = HiddenRows + BoardHeight;
    localparam int RowBits = $clog2(NumRows);

    // Settled cells, row 0 is the top hidden row
    logic [BoardWidth-1:0] grid [NumRows];

    logic               clearing;
    logic [RowBits-1:0] scanRow;
    logic [2:0]         removedCnt;
    logic               rowFull;
    logic               hiddenUsed;

    function automatic logic inBoard(cellXT x, cellYT y);
        return (x >= 0) && (x < BoardWidth) && (y >= 0) && (y < NumRows);
    endfunction

    // ####################################################################
    // Collision test of the candidate piece
    // ####################################################################

    always_comb begin
        hit = 1'b0;
        for (int i = 0; i < 4; i++) begin
            if (!inBoard(candX[i], candY[i])) begin
                hit = 1'b1;
            end else if (grid[int'(candY[i])][int'(candX[i])]) begin
                hit = 1'b1;
            end
        end
    end

    assign rowFull = &grid[scanRow];

    always_comb begin
        hiddenUsed = 1'b0;
        for (int r = 0; r < HiddenRows; r++) begin
            hiddenUsed = hiddenUsed | (|grid[r]);
        end
    end

    // ####################################################################
    // Lock and row clear
    // ####################################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < NumRows; r++) begin
                grid[r] <= '0;
            end
            clearing    <= 1'b0;
            scanRow     <= '0;
            removedCnt  <= '0;
            clearDone   <= 1'b0;
            rowsRemoved <= '0;
            overflow    <= 1'b0;
        end else begin
            clearDone <= 1'b0;

            if (lockPiece) begin
                for (int i = 0; i < 4; i++) begin
                    if (inBoard(curX[i], curY[i])) begin
                        grid[int'(curY[i])][int'(curX[i])] <= 1'b1;
                    end
                end
            end

            // Walk from the bottom row up, one row per cycle
            if (clearStart) begin
                clearing   <= 1'b1;
                scanRow    <= RowBits'(NumRows - 1);
                removedCnt <= '0;
            end else if (clearing) begin
                if (rowFull) begin
                    // Drop everything above and look at the same row again
                    for (int r = 1; r < NumRows; r++) begin
                        if (r <= scanRow) begin
                            grid[r] <= grid[r - 1];
                        end
                    end
                    grid[0]    <= '0;
                    removedCnt <= removedCnt + 3'd1;
                end else if (scanRow == '0) begin
                    clearing    <= 1'b0;
                    clearDone   <= 1'b1;
                    rowsRemoved <= removedCnt;
                    overflow    <= hiddenUsed;
                end else begin
                    scanRow <= scanRow - 1'b1;
                end
            end
        end
    end

    // ####################################################################
    // Board image of the visible rows
    // ####################################################################

    always_comb begin
        for (int r = 0; r < BoardHeight; r++) begin
            for (int c = 0; c < BoardWidth; c++) begin
                objects[BoardWidth * r + c] = grid[r + HiddenRows][c];
            end
        end
        // Active piece on top, hidden-row cells are not shown
        for (int i = 0; i < 4; i++) begin
            if (inBoard(curX[i], curY[i]) && (curY[i] >= HiddenRows)) begin
                objects[BoardWidth * (int'(curY[i]) - HiddenRows) + int'(curX[i])] = 1'b1;
            end
        end
    end

endmodule

/* rtl/pieceShapes.sv */
`timescale 1ns/1ps

module pieceShapes (
    input  tetrisPkg::pieceTypeT pieceType,
    input  tetrisPkg::rotationT  rotation,
    input  tetrisPkg::cellXT     centerX,
    input  tetrisPkg::cellYT     centerY,
    output tetrisPkg::cellXT     cellX [4],
    output tetrisPkg::cellYT     cellY [4]
);
    import tetrisPkg::*;

    cellXT    baseX [3];
    cellYT    baseY [3];
    cellXT    rotX  [3];
    cellYT    rotY  [3];
    rotationT turns;

    // Offsets around the centre at rotation 0, dy grows downward
    always_comb begin
        case (pieceType)
            3'd1: begin
                baseX = '{6'sd0, 6'sd1, 6'sd1};
                baseY = '{-6'sd1, -6'sd1, 6'sd0};
            end
            3'd2: begin
                baseX = '{-6'sd1, 6'sd0, 6'sd1};
                baseY = '{6'sd0, -6'sd1, 6'sd0};
            end
            3'd3: begin
                baseX = '{-6'sd1, 6'sd1, 6'sd1};
                baseY = '{6'sd0, 6'sd0, -6'sd1};
            end
            3'd4: begin
                baseX = '{-6'sd1, 6'sd0, 6'sd1};
                baseY = '{6'sd0, -6'sd1, -6'sd1};
            end
            // Bar, also used for unknown types
            default: begin
                baseX = '{-6'sd2, -6'sd1, 6'sd1};
                baseY = '{6'sd0, 6'sd0, 6'sd0};
            end
        endcase
    end

    // The square looks the same in every orientation
    assign turns = (pieceType == 3'd1) ? 2'd0 : rotation;

    // Each clockwise quarter turn maps (dx, dy) to (-dy, dx)
    always_comb begin
        cellX[0] = centerX;
        cellY[0] = centerY;
        for (int i = 0; i < 3; i++) begin
            case (turns)
                2'd1:    begin rotX[i] = -baseY[i]; rotY[i] = baseX[i];  end
                2'd2:    begin rotX[i] = -baseX[i]; rotY[i] = -baseY[i]; end
                2'd3:    begin rotX[i] = baseY[i];  rotY[i] = -baseX[i]; end
                default: begin rotX[i] = baseX[i];  rotY[i] = baseY[i];  end
            endcase
            cellX[i + 1] = centerX + rotX[i];
            cellY[i + 1] = centerY + rotY[i];
        end
    end

endmodule

/* rtl/keyInput.sv */
`timescale 1ns/1ps

module keyInput (
    input  logic              clk,
    input  logic              rst,
    input  logic              left,
    input  logic              right,
    input  logic              up,
    input  logic              down,
    output tetrisPkg::keyCmdT cmd
);
    import tetrisPkg::*;

    // Key vectors ordered {down, left, right, up}
    logic [3:0] keyQ;
    logic [3:0] keyPrev;
    logic [3:0] rise;

    // A key counts once, on the cycle after its level goes high
    assign rise = keyQ & ~keyPrev;

    always_ff @(posedge clk) begin
        if (rst) begin
            keyQ    <= '0;
            keyPrev <= '0;
            cmd     <= cmdNone;
        end else begin
            keyQ    <= {down, left, right, up};
            keyPrev <= keyQ;

            // Fixed priority when several keys rise together
            if (rise[3]) begin
                cmd <= cmdDrop;
            end else if (rise[2]) begin
                cmd <= cmdLeft;
            end else if (rise[1]) begin
                cmd <= cmdRight;
            end else if (rise[0]) begin
                cmd <= cmdRotate;
            end else begin
                cmd <= cmdNone;
            end
        end
    end

endmodule

/* rtl/tetrisPkg.sv */
package tetrisPkg;

    // ####################################################################
    // Board geometry
    // ####################################################################

    // Visible playing field
    localparam int BoardWidth  = 10;
    localparam int BoardHeight = 20;

    // Spawn rows sitting above the visible field
    localparam int HiddenRows = 4;

    localparam int NumPieceTypes = 5;

    // Spawn centre, row counted from the top hidden row
    localparam int SpawnX = 5;
    localparam int SpawnY = 2;

    // ####################################################################
    // Coordinates, pieces and score
    // ####################################################################

    // Signed so that cells left of the wall or above row 0 can be expressed
    typedef logic signed [5:0] cellXT;
    typedef logic signed [5:0] cellYT;

    typedef logic [2:0] pieceTypeT;
    typedef logic [1:0] rotationT;
    typedef logic [9:0] scoreT;

    // Points per landed piece and per removed row
    localparam int LandPoints = 1;
    localparam int LinePoints = 10;

    // ####################################################################
    // Commands and sequencer states
    // ####################################################################

    typedef enum logic [2:0] {
        cmdNone,
        cmdLeft,
        cmdRight,
        cmdRotate,
        cmdDrop
    } keyCmdT;

    typedef enum logic [2:0] {
        stIdle,
        stCheck,
        stLock,
        stClear,
        stSpawn,
        stOver
    } seqStateT;

endpackage
